// File: Makefile
# Verilator build and run of the commit back end testbench

LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module tb_ooo_commit -o Vtb_ooo_commit
	./obj_dir/Vtb_ooo_commit > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Regression passed" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f filelist.f \
		--top-module ooo_commit_top

clean:
	rm -rf obj_dir $(LOG)

// File: branch_history_table.sv
// branch history table of 2-bit saturating counters
// lookup is combinational on the fetch pc, training comes from
// resolved alu branches and takes effect at the next edge

`default_nettype none

`include "ooo_core_config.svh"

module branch_history_table (
  input  wire logic                           CLK,
  input  wire logic                           nRST,
  input  wire ooo_frontend_pkg::bp_update_t   bp_update,
  input  wire logic [`XLEN-1:0]               lookup_pc,
  output logic                                lookup_taken
);

  logic [1:0]            cnt [`BHT_ENTRIES];
  logic [`BHT_IDX_W-1:0] upd_idx, lk_idx;

  // word aligned pcs, so skip bits 1:0
  assign upd_idx = bp_update.pc[`BHT_IDX_W+1:2];
  assign lk_idx  = lookup_pc[`BHT_IDX_W+1:2];

  assign lookup_taken = cnt[lk_idx][1];  // msb is the prediction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `BHT_ENTRIES; i++) begin
        cnt[i] <= 2'b01;  // weakly not taken
      end
    end else if (bp_update.valid) begin
      if (bp_update.taken) begin
        if (cnt[upd_idx] != 2'b11) cnt[upd_idx] <= cnt[upd_idx] + 2'b01;
      end else begin
        if (cnt[upd_idx] != 2'b00) cnt[upd_idx] <= cnt[upd_idx] - 2'b01;
      end
    end
  end

endmodule

`default_nettype wire

// File: completion_buffer.sv
// completion buffer (reorder buffer) of the back end
// slots are allocated at the tail in program order, completed out of
// order by up to four writes per cycle and retired from the head over a
// valid/ready port. an exception at the head flushes the whole buffer

`default_nettype none

`include "ooo_core_config.svh"

module completion_buffer (
  input  wire logic                        CLK,
  input  wire logic                        nRST,
  input  wire ooo_commit_pkg::cb_write_t   wr_alu,
  input  wire ooo_commit_pkg::cb_write_t   wr_mul,
  input  wire ooo_commit_pkg::cb_write_t   wr_div,
  input  wire ooo_commit_pkg::cb_write_t   wr_ls,
  input  wire logic                        alloc_valid,
  output logic                             alloc_ready,
  output logic [`CB_IDX_W-1:0]             alloc_index,
  output ooo_commit_pkg::retire_t          retire,
  output logic                             retire_valid,
  input  wire logic                        retire_ready,
  output logic                             flush,
  output logic [`XLEN-1:0]                 epc
);

  localparam int CNT_W = `CB_IDX_W + 1;

  ooo_frontend_pkg::alloc_t      alloc_req;
  ooo_commit_pkg::cb_write_t     wr [4];           // alu, mul, div, ls

  logic [`CB_IDX_W-1:0]          head, tail;
  logic [CNT_W-1:0]              count;
  logic [`CB_DEPTH-1:0]          ent_valid;        // slot allocated
  logic [`CB_DEPTH-1:0]          ent_done;         // result written
  logic                          do_alloc, do_retire;

  // entry payload
  ooo_commit_pkg::result_word_u  word_q [`CB_DEPTH];
  logic [4:0]                    rd_q   [`CB_DEPTH];
  logic [`CB_DEPTH-1:0]          wen_q, exc_q, halt_q;

  assign alloc_req.valid         = alloc_valid;
  assign alloc_req.halt_expected = 1'b0;

  assign wr[0] = wr_alu;
  assign wr[1] = wr_mul;
  assign wr[2] = wr_div;
  assign wr[3] = wr_ls;

  // allocation side
  assign alloc_ready = (count != CNT_W'(`CB_DEPTH)) & ~flush;
  assign alloc_index = tail;
  assign do_alloc    = alloc_req.valid & alloc_ready;

  // retire side reads the head entry directly
  assign retire_valid    = ent_valid[head] & ent_done[head] & ~flush;
  assign retire.rd        = rd_q[head];
  assign retire.wen       = wen_q[head];
  assign retire.word      = word_q[head];
  assign retire.exception = exc_q[head];
  assign retire.halt      = halt_q[head];
  assign retire.index     = head;
  assign do_retire        = retire_valid & retire_ready;

  // control state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      ent_valid <= '0;
      ent_done  <= '0;
      flush     <= 1'b0;
      epc       <= '0;
    end else if (flush) begin
      // drop everything younger than the faulting entry
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      ent_valid <= '0;
      ent_done  <= '0;
      flush     <= 1'b0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (wr[i].ready) ent_done[wr[i].index] <= 1'b1;  // out of order
      end
      if (do_alloc) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= tail + 1'b1;  // wraps at depth
      end
      if (do_retire) begin
        ent_valid[head] <= 1'b0;
        ent_done[head]  <= 1'b0;
        head            <= head + 1'b1;
        if (retire.exception) begin
          flush <= 1'b1;  // held one cycle and cleared next edge
          epc   <= {{(`XLEN-30){1'b0}}, retire.word.fault.pc_word, 2'b00};
        end
      end
      count <= count + CNT_W'(do_alloc) - CNT_W'(do_retire);
    end
  end

  // payload is written by completion only
  always_ff @(posedge CLK) begin
    for (int i = 0; i < 4; i++) begin
      if (wr[i].ready) begin
        word_q[wr[i].index] <= wr[i].word;
        rd_q[wr[i].index]   <= wr[i].rd;
        wen_q[wr[i].index]  <= wr[i].wen;
        exc_q[wr[i].index]  <= wr[i].exception;
        halt_q[wr[i].index] <= wr[i].halt;
      end
    end
  end

  // each completion hits a live slot that has not completed yet
  for (genvar g = 0; g < 4; g++) begin : g_wr_chk
    a_wr_alloc: assert property (
      @(posedge CLK) disable iff (!nRST)
      (wr[g].ready && !flush) |-> (ent_valid[wr[g].index] && !ent_done[wr[g].index])
    ) else $error("completion to unallocated or finished slot %0d", wr[g].index);
  end

  // count tracks the allocated slots and never passes depth
  a_count_max: assert property (
    @(posedge CLK) disable iff (!nRST)
    (count <= CNT_W'(`CB_DEPTH)) && (count == CNT_W'($countones(ent_valid)))
  ) else $error("buffer count %0d over depth or out of step with valid slots", count);

  // back-pressure keeps the offered record steady
  a_retire_hold: assert property (
    @(posedge CLK) disable iff (!nRST)
    (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire))
  ) else $error("retire dropped or changed while stalled");

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
ooo_commit_pkg.sv
ooo_frontend_pkg.sv
ooo_commit_stage.sv
completion_buffer.sv
branch_history_table.sv
ooo_commit_top.sv
tb_commit_checker.sv
tb_ooo_commit.sv

// File: ooo_commit_pkg.sv
// types shared between the execution units, the commit stage and the
// completion buffer. unit results come in as fu_result_t, get reformatted
// into cb_write_t and leave the buffer as retire_t

`default_nettype none

`include "ooo_core_config.svh"

package ooo_commit_pkg;

  // fault causes written into the fault view
  localparam logic [3:0] CAUSE_MIS_INSN = 4'd0;  // misaligned jump/branch target
  localparam logic [3:0] CAUSE_MIS_DATA = 4'd4;  // misaligned load/store address

  // one execution unit result
  // for the load/store unit jump_addr carries the data address
  typedef struct packed {
    logic                 done;
    logic [`CB_IDX_W-1:0] index;         // buffer slot from allocation
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     wdata;
    logic [4:0]           rd;
    logic                 wen;
    logic                 exception;
    logic [3:0]           cause;
    logic                 jump_instr;
    logic [`XLEN-1:0]     jump_addr;     // resolved target, or ls address
    logic                 branch_instr;
    logic                 branch_taken;
    logic                 prediction;
    logic                 halt_instr;
  } fu_result_t;

  // fault record, same width as one data word
  typedef struct packed {
    logic [3:0]       cause;
    logic [`XLEN-5:0] pc_word;           // pc bits 29:2
  } fault_rec_t;

  // one stored word, read as data or as fault by the exception flag
  typedef union packed {
    logic [`XLEN-1:0] data;
    fault_rec_t       fault;
  } result_word_u;

  // one completion write into the buffer
  typedef struct packed {
    logic                 ready;
    logic [`CB_IDX_W-1:0] index;
    result_word_u         word;
    logic [4:0]           rd;
    logic                 wen;
    logic                 exception;
    logic                 halt;
  } cb_write_t;

  // head entry as seen by the retire port
  typedef struct packed {
    logic [4:0]           rd;
    logic                 wen;
    result_word_u         word;
    logic                 exception;
    logic                 halt;
    logic [`CB_IDX_W-1:0] index;
  } retire_t;

endpackage

`default_nettype wire

// File: ooo_commit_stage.sv
// commit stage of the out-of-order back end
// turns the four unit results into completion buffer writes, detects
// misaligned targets and data addresses, and trains the predictor
// from alu branches. purely combinational apart from the pc tracker

`default_nettype none

`include "ooo_core_config.svh"

module ooo_commit_stage (
  input  wire logic                          CLK,
  input  wire logic                          nRST,
  input  wire ooo_commit_pkg::fu_result_t    res_alu,
  input  wire ooo_commit_pkg::fu_result_t    res_mul,
  input  wire ooo_commit_pkg::fu_result_t    res_div,
  input  wire ooo_commit_pkg::fu_result_t    res_ls,
  output ooo_commit_pkg::cb_write_t          wr_alu,
  output ooo_commit_pkg::cb_write_t          wr_mul,
  output ooo_commit_pkg::cb_write_t          wr_div,
  output ooo_commit_pkg::cb_write_t          wr_ls,
  output ooo_frontend_pkg::bp_update_t       bp_update
);

  logic [`XLEN-1:0] last_pc;  // last nonzero alu pc seen

  // one result to one buffer write
  function automatic ooo_commit_pkg::cb_write_t fmt_result(
    input ooo_commit_pkg::fu_result_t r,
    input logic                       is_ls
  );
    ooo_commit_pkg::cb_write_t w;
    logic tgt_mis;
    logic data_mis;
    tgt_mis  = (r.jump_instr | r.branch_instr) & (r.jump_addr[1:0] != 2'b00);
    data_mis = is_ls & (r.jump_addr[1:0] != 2'b00);  // word access only
    w.ready     = r.done;       // branches still complete their slot
    w.index     = r.index;
    w.rd        = r.rd;
    w.halt      = r.halt_instr;
    w.exception = r.exception | tgt_mis | data_mis;
    w.wen       = r.wen & ~w.exception & ~r.branch_instr;
    if (w.exception) begin
      // unit cause first, then our own misalignment checks
      w.word.fault.cause   = r.exception ? r.cause :
                             tgt_mis ? ooo_commit_pkg::CAUSE_MIS_INSN :
                             ooo_commit_pkg::CAUSE_MIS_DATA;
      w.word.fault.pc_word = r.pc[29:2];
    end else if (r.jump_instr) begin
      w.word.data = r.pc + `XLEN'd4;  // link address
    end else begin
      w.word.data = r.wdata;
    end
    return w;
  endfunction

  assign wr_alu = fmt_result(res_alu, 1'b0);
  assign wr_mul = fmt_result(res_mul, 1'b0);
  assign wr_div = fmt_result(res_div, 1'b0);
  assign wr_ls  = fmt_result(res_ls,  1'b1);

  // only the alu resolves branches
  assign bp_update.valid = res_alu.done & res_alu.branch_instr;
  assign bp_update.pc    = res_alu.pc;
  assign bp_update.taken = res_alu.branch_taken;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      last_pc <= '0;
    end else if (res_alu.done && (res_alu.pc != '0)) begin
      last_pc <= res_alu.pc;
    end
  end

  // a completing alu op always comes from a fetched pc
  a_alu_pc_valid: assert property (
    @(posedge CLK) disable iff (!nRST)
    res_alu.done |-> (res_alu.pc != '0)
  ) else $error("alu result with zero pc, last valid pc %h", last_pc);

endmodule

`default_nettype wire

// File: ooo_commit_top.sv
// top of the commit back end
// results from the four execution units go through the commit stage
// into the completion buffer, resolved alu branches train the history table

`default_nettype none

`include "ooo_core_config.svh"

module ooo_commit_top (
  input  wire logic                        CLK,
  input  wire logic                        nRST,
  input  wire ooo_commit_pkg::fu_result_t  res_alu,
  input  wire ooo_commit_pkg::fu_result_t  res_mul,
  input  wire ooo_commit_pkg::fu_result_t  res_div,
  input  wire ooo_commit_pkg::fu_result_t  res_ls,
  input  wire logic                        alloc_valid,
  output logic                             alloc_ready,
  output logic [`CB_IDX_W-1:0]             alloc_index,
  output ooo_commit_pkg::retire_t          retire,
  output logic                             retire_valid,
  input  wire logic                        retire_ready,
  input  wire logic [`XLEN-1:0]            lookup_pc,
  output logic                             lookup_taken,
  output logic                             flush,
  output logic [`XLEN-1:0]                 epc
);

  ooo_commit_pkg::cb_write_t     wr_alu, wr_mul, wr_div, wr_ls;
  ooo_frontend_pkg::bp_update_t  bp_update;

  ooo_commit_stage u_commit (
    .CLK, .nRST,
    .res_alu, .res_mul, .res_div, .res_ls,
    .wr_alu, .wr_mul, .wr_div, .wr_ls,
    .bp_update
  );

  completion_buffer u_cb (
    .CLK, .nRST,
    .wr_alu, .wr_mul, .wr_div, .wr_ls,
    .alloc_valid, .alloc_ready, .alloc_index,
    .retire, .retire_valid, .retire_ready,
    .flush, .epc
  );

  branch_history_table u_bht (
    .CLK, .nRST,
    .bp_update,
    .lookup_pc, .lookup_taken
  );

endmodule

`default_nettype wire

// File: ooo_core_config.svh
// sizing macros for the out-of-order commit back end
// include in any file that needs data width, buffer depth or table size
// the types built on these live in the two packages

`ifndef OOO_CORE_CONFIG_SVH
`define OOO_CORE_CONFIG_SVH

// register and pc width
`define XLEN 32

// completion buffer entries and slot index width
`define CB_DEPTH 8
`define CB_IDX_W 3

// branch history table counters and index width
`define BHT_ENTRIES 16
`define BHT_IDX_W 4

`endif

// File: ooo_frontend_pkg.sv
// types facing the front end: slot allocation from dispatch and
// training records for the branch history table
// allocation carries only valid for now

`default_nettype none

`include "ooo_core_config.svh"

package ooo_frontend_pkg;

  // dispatch side slot request
  typedef struct packed {
    logic valid;
    logic halt_expected;   // spare, tied low in this core
  } alloc_t;

  // predictor training from a resolved branch
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;      // branch pc, bits [5:2] pick the counter
    logic             taken;
  } bp_update_t;

endpackage

`default_nettype wire

// File: tb_commit_checker.sv
// checker for the commit back end testbench
// keeps a queue model of allocated slots, a slot count and a counter
// model of the history table, and compares the DUT ports every edge

`default_nettype none

`include "ooo_core_config.svh"

module tb_commit_checker (
  input  wire logic                       CLK,
  input  wire logic                       nRST,
  input  wire logic                       alloc_valid,
  input  wire logic                       alloc_ready,
  input  wire logic [`CB_IDX_W-1:0]       alloc_index,
  input  wire ooo_commit_pkg::retire_t    retire,
  input  wire logic                       retire_valid,
  input  wire logic                       retire_ready,
  input  wire logic                       flush,
  input  wire logic [31:0]                epc,
  input  wire logic [31:0]                lookup_pc,
  input  wire logic                       lookup_taken,
  input  wire ooo_commit_pkg::fu_result_t res_alu,
  input  wire ooo_commit_pkg::retire_t    exp_rec,
  input  wire logic [31:0]                exp_pc,
  input  wire logic                       test_end,
  input  wire integer                     test_kind,
  output int                              errors,
  output int                              checks
);
  timeunit 1ns;
  timeprecision 1ps;

  ooo_commit_pkg::retire_t exp_q [$];
  logic [31:0] pc_q [$];
  logic [`CB_IDX_W-1:0] tail;
  int count, test_num, base_err;
  logic flush_exp, stalled;
  logic [31:0] flush_pc;
  ooo_commit_pkg::retire_t held;
  logic [1:0] bht [16];  // counter model

  function automatic string kind_name(input int k);
    case (k)
      0: return "plain results";
      1: return "jumps and branches";
      2: return "exceptions and flush";
      3: return "full and back-pressure";
      default: return "branch history";
    endcase
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge CLK or negedge nRST) begin
    ooo_commit_pkg::retire_t e;
    logic [31:0] p;
    logic flush_nx;
    logic acc;
    if (!nRST) begin
      exp_q.delete();
      pc_q.delete();
      tail = '0;
      count = 0;
      flush_exp = 1'b0;
      flush_pc = '0;
      stalled = 1'b0;
      held = '0;
      for (int i = 0; i < 16; i++) bht[i] = 2'b01;
    end else begin
      flush_nx = 1'b0;
      acc = alloc_valid && (count < `CB_DEPTH) && !flush_exp;
      check_val("alloc_ready", alloc_ready, (count < `CB_DEPTH) && !flush_exp);
      check_val("alloc_index", alloc_index, tail);
      check_val("flush", flush, flush_exp);
      if (flush_exp) check_val("epc", epc, flush_pc);
      if (stalled) begin  // stalled last edge so the offer must hold
        check_val("retire_valid", retire_valid, 1'b1);
        check_val("retire", retire, held);
      end
      check_val("lookup_taken", lookup_taken, bht[lookup_pc[5:2]][1]);
      if (retire_valid && retire_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("t=%0t the DUT retired an entry that was never allocated", $time);
        end else begin
          e = exp_q.pop_front();
          p = pc_q.pop_front();
          check_val("retire.rd", retire.rd, e.rd);
          check_val("retire.wen", retire.wen, e.wen);
          check_val("retire.word", retire.word, e.word);
          check_val("retire.exception", retire.exception, e.exception);
          check_val("retire.halt", retire.halt, e.halt);
          check_val("retire.index", retire.index, e.index);
          flush_nx = e.exception;
          if (e.exception) flush_pc = p;
        end
        count--;
      end
      stalled = retire_valid && !retire_ready;
      held = retire;
      if (acc) begin
        e = exp_rec;
        e.index = tail;
        exp_q.push_back(e);
        pc_q.push_back(exp_pc);
        tail++;
        count++;
      end
      if (res_alu.done && res_alu.branch_instr) begin  // saturating train
        p = res_alu.pc;
        if (res_alu.branch_taken && bht[p[5:2]] != 2'b11) bht[p[5:2]]++;
        if (!res_alu.branch_taken && bht[p[5:2]] != 2'b00) bht[p[5:2]]--;
      end
      if (flush_exp) begin  // younger slots are gone
        exp_q.delete();
        pc_q.delete();
        tail = '0;
        count = 0;
      end
      flush_exp = flush_nx;
      if (test_end) begin
        if (exp_q.size() != 0) begin  // drained buffer leaves nothing behind
          errors++;
          $display("t=%0t %0d allocated records were never retired", $time, exp_q.size());
        end
        $display("test %0d %s: %0d errors", test_num, kind_name(test_kind), errors - base_err);
        test_num++;
        base_err = errors;
      end
    end
  end

  initial begin
    errors = 0;
    checks = 0;
    test_num = 0;
    base_err = 0;
  end

endmodule

`default_nettype wire

// File: tb_ooo_commit.sv
// testbench top for the commit back end
// allocates slots with random results, completes them out of order from
// random units, then drains the retire port with random back-pressure
// tb_commit_checker holds the reference model and does all comparing

`default_nettype none

`include "ooo_core_config.svh"

module tb_ooo_commit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 15;
  localparam logic [31:0] BHT_PC = 32'h0000_1040;  // counter 0

  logic CLK, nRST;
  ooo_commit_pkg::fu_result_t res_alu, res_mul, res_div, res_ls;
  logic alloc_valid, alloc_ready, retire_valid, retire_ready;
  logic [`CB_IDX_W-1:0] alloc_index;
  ooo_commit_pkg::retire_t retire, exp_rec;
  logic [31:0] lookup_pc, epc, exp_pc;
  logic lookup_taken, flush, test_end;
  int test_kind, errors, checks;
  ooo_commit_pkg::fu_result_t slot_res [`CB_DEPTH];
  int slot_unit [`CB_DEPTH];
  int pending [$];

  ooo_commit_top u_dut (
    .CLK, .nRST, .res_alu, .res_mul, .res_div, .res_ls,
    .alloc_valid, .alloc_ready, .alloc_index,
    .retire, .retire_valid, .retire_ready,
    .lookup_pc, .lookup_taken, .flush, .epc
  );

  tb_commit_checker u_chk (
    .CLK, .nRST, .alloc_valid, .alloc_ready, .alloc_index,
    .retire, .retire_valid, .retire_ready, .flush, .epc,
    .lookup_pc, .lookup_taken, .res_alu, .exp_rec, .exp_pc,
    .test_end, .test_kind, .errors, .checks
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // random result of one kind, with the retire record it should produce
  function automatic void make_result(input int kind, input int j,
      output ooo_commit_pkg::fu_result_t r, output ooo_commit_pkg::retire_t e,
      output int unit);
    int sub;
    logic fault;
    logic [3:0] cause;
    r = '0;
    e = '0;
    fault = 1'b0;
    cause = 4'd0;
    r.done = 1'b1;
    r.pc = {2'b00, 28'($urandom), 2'b00} | 32'h100;  // never zero
    r.wdata = $urandom;
    r.rd = 5'($urandom);
    r.wen = 1'($urandom);
    r.halt_instr = 1'($urandom);
    r.jump_addr = $urandom & 32'hffff_fffc;
    unit = $urandom % 4;
    sub = $urandom % 4;
    e.rd = r.rd;
    e.wen = r.wen;
    e.halt = r.halt_instr;
    e.word.data = r.wdata;
    if (kind == 1) begin
      r.jump_instr = (sub == 0 || sub == 2);
      r.branch_instr = (sub == 1 || sub == 3);
      if (r.branch_instr) unit = 0;  // alu resolves branches
      r.branch_taken = 1'($urandom);
      if (sub >= 2) begin
        r.jump_addr = r.jump_addr | 32'h1 << (sub - 2);
        fault = 1'b1;
      end else if (sub == 0) begin
        e.word.data = r.pc + 32'd4;  // link value
      end else begin
        e.wen = 1'b0;
      end
    end else if (kind == 2 && sub == 2) begin
      r.exception = 1'b1;
      r.cause = 4'($urandom);
      cause = r.cause;
      fault = 1'b1;
    end else if (kind == 2 && sub == 3) begin
      unit = 3;
      r.jump_addr = r.jump_addr | 32'h2;  // bad data address
      cause = 4'd4;
      fault = 1'b1;
    end else if (kind == 4) begin
      unit = 0;
      r.pc = BHT_PC;
      r.branch_instr = 1'b1;
      r.branch_taken = (j < 3);  // up to 11, then down past 00
      e.wen = 1'b0;
    end
    if (fault) begin
      e.exception = 1'b1;
      e.wen = 1'b0;
      e.word.data = {cause, r.pc[29:2]};
    end
  endfunction

  task automatic run_test(input int t);
    ooo_commit_pkg::fu_result_t r;
    ooo_commit_pkg::retire_t e;
    int unit, n, p, idx, stall;
    test_kind <= t % 5;
    n = (t % 5 == 3) ? `CB_DEPTH + 1 : (t % 5 == 4) ? 8 : 1 + $urandom % `CB_DEPTH;
    for (int j = 0; j < n; j++) begin
      make_result(t % 5, j, r, e, unit);
      @(posedge CLK);
      alloc_valid <= 1'b1;
      exp_rec <= e;
      exp_pc <= r.pc;
      @(posedge CLK);
      alloc_valid <= 1'b0;
      if (alloc_ready) begin  // refused when full
        r.index = alloc_index;
        slot_res[alloc_index] = r;
        slot_unit[alloc_index] = unit;
        pending.push_back(alloc_index);
      end
    end
    while (pending.size() > 0) begin
      @(posedge CLK);
      res_alu <= '0;
      res_mul <= '0;
      res_div <= '0;
      res_ls  <= '0;
      if ($urandom % 3 != 0) begin  // idle cycles shuffle timing
        p = (t % 5 == 4) ? 0 : $urandom % pending.size();
        idx = pending[p];
        pending.delete(p);
        case (slot_unit[idx])
          0: res_alu <= slot_res[idx];
          1: res_mul <= slot_res[idx];
          2: res_div <= slot_res[idx];
          default: res_ls <= slot_res[idx];
        endcase
      end
    end
    @(posedge CLK);
    res_alu <= '0;
    res_mul <= '0;
    res_div <= '0;
    res_ls  <= '0;
    stall = (t % 5 == 3) ? 6 : 0;
    forever begin
      @(posedge CLK);
      if (!retire_valid && !flush) break;  // empty
      retire_ready <= (stall > 0) ? 1'b0 : 1'($urandom);
      stall--;
    end
    retire_ready <= 1'b0;
    test_end <= 1'b1;
    @(posedge CLK);
    test_end <= 1'b0;
  endtask

  // lookup follows the trained pc in the history test
  always @(posedge CLK) begin
    lookup_pc <= (test_kind == 4) ? BHT_PC : ($urandom & 32'h0000_00fc);
  end

  initial begin
    void'($urandom(32'h5896f5f7));
    nRST = 1'b0;
    res_alu = '0;
    res_mul = '0;
    res_div = '0;
    res_ls = '0;
    alloc_valid = 1'b0;
    retire_ready = 1'b0;
    lookup_pc = '0;
    exp_rec = '0;
    exp_pc = '0;
    test_end = 1'b0;
    test_kind = 0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    repeat (2) @(posedge CLK);
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog allows 200 cycles per test plus margin
  initial begin
    #((200 * NUM_TESTS + 1000) * 10);
    $display("run did not finish in time, stuck waiting on the DUT");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
